// ==== Makefile ====
# Verilator build and run for the matrix-multiply control subsystem

VERILATOR ?= verilator
TOP       ?= tb_mm_accel
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
hw/mm_pkg.sv
hw/mm_cfg_slave.sv
hw/mm_tiler.sv
hw/mm_ctrl.sv
hw/mm_tile_sched.sv
hw/mm_accel_top.sv
tb/mm_accel_asserts.sv
tb/tb_mm_accel.sv

// ==== hw/mm_accel_top.sv ====
////////////////////////////////////////////////////////////
// Matrix-multiply control subsystem top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mm_accel_top import mm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  periph_req_t req_i,
  output periph_rsp_t rsp_o,
  output logic        busy_o,
  output logic        evt_o,
  output tile_cmd_t   tile_o
);

  sched_ctrl_t sched_ctrl;
  job_cfg_t    job_cfg;
  tile_cnt_t   tile_cnt;
  logic        w_loaded, done;

  // Register port, job FSM, slave and tiler
  mm_ctrl i_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .rsp_o      (rsp_o),
    .w_loaded_i (w_loaded),
    .done_i     (done),
    .busy_o     (busy_o),
    .evt_o      (evt_o),
    .sched_o    (sched_ctrl),
    .cfg_o      (job_cfg),
    .cnt_o      (tile_cnt)
  );

  // Tile commands go straight out
  mm_tile_sched i_sched (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sched_i    (sched_ctrl),
    .cfg_i      (job_cfg),
    .cnt_i      (tile_cnt),
    .w_loaded_o (w_loaded),
    .done_o     (done),
    .tile_o     (tile_o)
  );

endmodule

// ==== hw/mm_cfg_slave.sv ====
////////////////////////////////////////////////////////////
// Configuration slave: dimension registers, trigger and
// status readback over the register port
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mm_cfg_slave import mm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  periph_req_t req_i,
  output periph_rsp_t rsp_o,
  input  logic        busy_i,
  input  logic        setback_i,
  output logic        trigger_o,
  output logic        start_req_o,
  output job_cfg_t    cfg_o
);

  logic [DIM_W-1:0] m_q, n_q, k_q;
  logic             wr_en, rd_en, trigger_wr;
  logic             trigger_q, start_req_q;
  logic             rvalid_q;
  logic [REG_W-1:0] rdata, rdata_q;

  // Access decode
  assign wr_en = req_i.valid & req_i.we;
  assign rd_en = req_i.valid & ~req_i.we;
  assign trigger_wr = wr_en && (req_i.addr == ADDR_TRIGGER);

  // Dimension registers, low DIM_W bits of the write data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_q <= '0;
      n_q <= '0;
      k_q <= '0;
    end else if (wr_en) begin
      case (req_i.addr)
        ADDR_M: m_q <= req_i.wdata[DIM_W-1:0];
        ADDR_N: n_q <= req_i.wdata[DIM_W-1:0];
        ADDR_K: k_q <= req_i.wdata[DIM_W-1:0];
        default: ;
      endcase
    end
  end

  // Trigger strobe and sticky start request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trigger_q <= 1'b0;
      start_req_q <= 1'b0;
    end else begin
      trigger_q <= trigger_wr;
      // New trigger wins over setback
      if (trigger_wr) begin
        start_req_q <= 1'b1;
      end else if (setback_i) begin
        start_req_q <= 1'b0;
      end
    end
  end

  // Read mux, status carries busy in bit 0
  always_comb begin
    case (req_i.addr)
      ADDR_STATUS: rdata = REG_W'(busy_i);
      ADDR_M: rdata = REG_W'(m_q);
      ADDR_N: rdata = REG_W'(n_q);
      ADDR_K: rdata = REG_W'(k_q);
      default: rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata = rdata_q;
  assign trigger_o = trigger_q;
  assign start_req_o = start_req_q;
  assign cfg_o.m = m_q;
  assign cfg_o.n = n_q;
  assign cfg_o.k = k_q;

endmodule

// ==== hw/mm_ctrl.sv ====
////////////////////////////////////////////////////////////
// Job controller: slave, tiler and the job phase FSM
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mm_ctrl import mm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  periph_req_t req_i,
  output periph_rsp_t rsp_o,
  input  logic        w_loaded_i,
  input  logic        done_i,
  output logic        busy_o,
  output logic        evt_o,
  output sched_ctrl_t sched_o,
  output job_cfg_t    cfg_o,
  output tile_cnt_t   cnt_o
);

  typedef enum logic [1:0] {
    IDLE,
    STARTING,
    COMPUTING,
    FINISHED
  } state_e;

  state_e state_q, state_d;
  logic   trigger, start_req, setback, tiler_valid;

  mm_cfg_slave i_slave (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .rsp_o       (rsp_o),
    .busy_i      (busy_o),
    .setback_i   (setback),
    .trigger_o   (trigger),
    .start_req_o (start_req),
    .cfg_o       (cfg_o)
  );

  mm_tiler i_tiler (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .trigger_i (trigger),
    .setback_i (setback),
    .cfg_i     (cfg_o),
    .valid_o   (tiler_valid),
    .cnt_o     (cnt_o)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Launch needs both a pending request and valid counts
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start_req && tiler_valid) state_d = STARTING;
      STARTING: if (w_loaded_i) state_d = COMPUTING;
      COMPUTING: if (done_i) state_d = FINISHED;
      FINISHED: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Setback consumes request and counts at launch
  assign setback = (state_q == IDLE) && (state_d == STARTING);
  assign busy_o = state_q != IDLE;
  assign evt_o = state_q == FINISHED;
  assign sched_o.first_load = state_q == STARTING;
  assign sched_o.finished = state_q == FINISHED;

endmodule

// ==== hw/mm_pkg.sv ====
////////////////////////////////////////////////////////////
// Matrix-multiply control package
// Tile geometry, register map and bus structs
////////////////////////////////////////////////////////////
package mm_pkg;

  // Job dimension and tile index widths
  localparam int unsigned DIM_W = 16;
  localparam int unsigned TILE_W = 12;
  localparam int unsigned REG_W = 32;

  // Output tile geometry
  localparam int unsigned TILE_ROWS = 16;
  localparam int unsigned TILE_COLS = 8;
  localparam int unsigned TILE_ROWS_LOG2 = $clog2(TILE_ROWS);
  localparam int unsigned TILE_COLS_LOG2 = $clog2(TILE_COLS);

  // Register map, word addresses
  localparam logic [2:0] ADDR_TRIGGER = 3'd0;
  localparam logic [2:0] ADDR_STATUS = 3'd1;
  localparam logic [2:0] ADDR_M = 3'd2;
  localparam logic [2:0] ADDR_N = 3'd3;
  localparam logic [2:0] ADDR_K = 3'd4;

  // Host register access
  typedef struct packed {
    logic             valid;
    logic             we;
    logic [2:0]       addr;
    logic [REG_W-1:0] wdata;
  } periph_req_t;

  // Read response, one cycle after the request
  typedef struct packed {
    logic             rvalid;
    logic [REG_W-1:0] rdata;
  } periph_rsp_t;

  typedef struct packed {
    logic [DIM_W-1:0] m;
    logic [DIM_W-1:0] n;
    logic [DIM_W-1:0] k;
  } job_cfg_t;

  typedef struct packed {
    logic [TILE_W-1:0] m_tiles;
    logic [TILE_W-1:0] n_tiles;
  } tile_cnt_t;

  // Controller to scheduler
  typedef struct packed {
    logic first_load;
    logic finished;
  } sched_ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [TILE_W-1:0] row;
    logic [TILE_W-1:0] col;
    logic              last;
  } tile_cmd_t;

endpackage

// ==== hw/mm_tile_sched.sv ====
////////////////////////////////////////////////////////////
// Tile scheduler: weight-load wait, then row-major tiles
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mm_tile_sched import mm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  sched_ctrl_t sched_i,
  input  job_cfg_t    cfg_i,
  input  tile_cnt_t   cnt_i,
  output logic        w_loaded_o,
  output logic        done_o,
  output tile_cmd_t   tile_o
);

  logic [DIM_W-1:0]  w_cnt_q, k_last;
  logic [TILE_W-1:0] row_q, col_q, row_last, col_last;
  logic              issue_q, done_q;
  logic              w_loaded, col_end, row_end, tile_last;

  // Weight load lasts max(k,1) cycles
  assign k_last = (cfg_i.k == '0) ? '0 : cfg_i.k - DIM_W'(1);
  assign w_loaded = sched_i.first_load && (w_cnt_q == k_last);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_cnt_q <= '0;
    end else if (sched_i.finished || w_loaded) begin
      w_cnt_q <= '0;
    end else if (sched_i.first_load) begin
      w_cnt_q <= w_cnt_q + DIM_W'(1);
    end
  end

  // End of row and end of job
  assign row_last = cnt_i.m_tiles - TILE_W'(1);
  assign col_last = cnt_i.n_tiles - TILE_W'(1);
  assign col_end = col_q == col_last;
  assign row_end = row_q == row_last;
  assign tile_last = issue_q && col_end && row_end;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q <= 1'b0;
      done_q <= 1'b0;
      row_q <= '0;
      col_q <= '0;
    end else begin
      // Done one cycle after the last command
      done_q <= tile_last;
      if (w_loaded) begin
        issue_q <= 1'b1;
      end else if (tile_last) begin
        issue_q <= 1'b0;
      end
      // Column varies fastest; hold at the end until finished
      if (sched_i.finished) begin
        row_q <= '0;
        col_q <= '0;
      end else if (issue_q && !tile_last) begin
        if (col_end) begin
          col_q <= '0;
          row_q <= row_q + TILE_W'(1);
        end else begin
          col_q <= col_q + TILE_W'(1);
        end
      end
    end
  end

  assign w_loaded_o = w_loaded;
  assign done_o = done_q;
  assign tile_o.valid = issue_q;
  assign tile_o.row = row_q;
  assign tile_o.col = col_q;
  assign tile_o.last = tile_last;

endmodule

// ==== hw/mm_tiler.sv ====
////////////////////////////////////////////////////////////
// Tiler: rounds job dimensions up to output tile counts
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mm_tiler import mm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      trigger_i,
  input  logic      setback_i,
  input  job_cfg_t  cfg_i,
  output logic      valid_o,
  output tile_cnt_t cnt_o
);

  logic      valid_q;
  tile_cnt_t cnt_d, cnt_q;

  // Ceiling of dim over 2**size_log2, zero clamped to one tile
  function automatic logic [TILE_W-1:0] tiles_of(input logic [DIM_W-1:0] dim,
                                                  input int unsigned size,
                                                  input int unsigned size_log2);
    logic [DIM_W:0] sum;
    sum = {1'b0, dim} + (DIM_W+1)'(size - 1);
    if (dim == '0) begin
      return TILE_W'(1);
    end
    return TILE_W'(sum >> size_log2);
  endfunction

  assign cnt_d.m_tiles = tiles_of(cfg_i.m, TILE_ROWS, TILE_ROWS_LOG2);
  assign cnt_d.n_tiles = tiles_of(cfg_i.n, TILE_COLS, TILE_COLS_LOG2);

  // Valid until the controller launches; a fresh trigger relatches
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (trigger_i) begin
      valid_q <= 1'b1;
    end else if (setback_i) begin
      valid_q <= 1'b0;
    end
  end

  // Counts
  always_ff @(posedge clk_i) begin
    if (trigger_i) begin
      cnt_q <= cnt_d;
    end
  end

  assign valid_o = valid_q;
  assign cnt_o = cnt_q;

endmodule

// ==== tb/mm_accel_asserts.sv ====
////////////////////////////////////////////////////////////
// Protocol assertions for the accelerator top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mm_accel_asserts import mm_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  input periph_req_t req_i,
  input periph_rsp_t rsp_o,
  input logic        busy_o,
  input logic        evt_o,
  input tile_cmd_t   tile_o
);

  // Completion event is a single-cycle strobe
  a_evt_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_o |=> !evt_o)
    else $error("evt_o stayed high for more than one cycle");

  // Tiles only go out during a job
  a_tile_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tile_o.valid |-> busy_o)
    else $error("tile_o.valid high while busy_o is low");

  // Read response exactly one cycle after the request
  a_rvalid_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.valid && !req_i.we) |=> rsp_o.rvalid)
    else $error("rsp_o.rvalid missing one cycle after a read");

  a_rvalid_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.rvalid |-> $past(req_i.valid && !req_i.we))
    else $error("rsp_o.rvalid without a read in the cycle before");

  a_last_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tile_o.last |-> tile_o.valid)
    else $error("tile_o.last high without tile_o.valid");

endmodule

bind mm_accel_top mm_accel_asserts i_asserts (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .req_i  (req_i),
  .rsp_o  (rsp_o),
  .busy_o (busy_o),
  .evt_o  (evt_o),
  .tile_o (tile_o)
);

// ==== tb/tb_mm_accel.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the matrix-multiply control top
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_mm_accel import mm_pkg::*; ();

  localparam int unsigned NUM_JOBS = 10;
  localparam int unsigned SEED = 32'h0ef165a4;

  logic        clk;
  logic        rst_n;
  periph_req_t req;
  periph_rsp_t rsp;
  logic        busy;
  logic        evt;
  tile_cmd_t   tile;

  // Job 0 random, 1 to 4 edge sizes, 5 busy, 6 and 7 queued pair, 8 and 9 reset
  job_cfg_t    jobs [NUM_JOBS];
  tile_cmd_t   tile_q [$];
  int          evt_cnt = 0;
  int          err_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;

  mm_accel_top UUT (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .req_i  (req),
    .rsp_o  (rsp),
    .busy_o (busy),
    .evt_o  (evt),
    .tile_o (tile)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT did not finish its jobs", cycle_cnt);
      $display("Test failures found");
      $fatal(1);
    end
  end

  // Collect tile commands and completion events
  always @(negedge clk) begin
    if (rst_n && tile.valid) begin
      tile_q.push_back(tile);
    end
    if (rst_n && evt) begin
      evt_cnt++;
    end
  end

  // Ceiling rule with a zero dimension still taking one tile
  function automatic int tiles_for(input int dim, input int size);
    if (dim == 0) begin
      return 1;
    end
    return (dim + size - 1) / size;
  endfunction

  function automatic int job_budget(input job_cfg_t j);
    return int'(j.k) + tiles_for(int'(j.m), int'(TILE_ROWS))
           * tiles_for(int'(j.n), int'(TILE_COLS)) + 50;
  endfunction

  function automatic job_cfg_t make_job(input int m, input int n, input int k);
    job_cfg_t j;
    j.m = DIM_W'(m);
    j.n = DIM_W'(n);
    j.k = DIM_W'(k);
    return j;
  endfunction

  task automatic stop_on_error();
    err_cnt++;
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic compare_rsp(input periph_rsp_t got, input periph_rsp_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: rsp_o got rvalid=%0b rdata=%h, expected rvalid=%0b rdata=%h",
               $time, got.rvalid, got.rdata, exp.rvalid, exp.rdata);
      stop_on_error();
    end
  endtask

  task automatic compare_tile(input tile_cmd_t got, input tile_cmd_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: tile_o got v=%0b r=%0d c=%0d l=%0b, expected v=%0b r=%0d c=%0d l=%0b",
               $time, got.valid, got.row, got.col, got.last,
               exp.valid, exp.row, exp.col, exp.last);
      stop_on_error();
    end
  endtask

  task automatic compare_busy(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: busy_o got %0b expected %0b", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0b expected %0b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic reg_write(input logic [2:0] addr, input logic [REG_W-1:0] data);
    periph_req_t r;
    r.valid = 1'b1;
    r.we = 1'b1;
    r.addr = addr;
    r.wdata = data;
    @(posedge clk);
    req <= r;
    @(posedge clk);
    req <= '0;
  endtask

  task automatic reg_read(input logic [2:0] addr, input logic [REG_W-1:0] data);
    periph_req_t r;
    periph_rsp_t e;
    r.valid = 1'b1;
    r.we = 1'b0;
    r.addr = addr;
    r.wdata = '0;
    e.rvalid = 1'b1;
    e.rdata = data;
    @(posedge clk);
    req <= r;
    // Nothing back in the request cycle itself
    @(negedge clk);
    compare_flag("rsp_o.rvalid", rsp.rvalid, 1'b0);
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    compare_rsp(rsp, e);
  endtask

  task automatic clear_monitor();
    tile_q.delete();
    evt_cnt = 0;
  endtask

  task automatic start_job(input job_cfg_t j);
    reg_write(ADDR_M, REG_W'(j.m));
    reg_write(ADDR_N, REG_W'(j.n));
    reg_write(ADDR_K, REG_W'(j.k));
    reg_write(ADDR_TRIGGER, '0);
  endtask

  task automatic wait_evt(input int n);
    while (evt_cnt < n) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_busy();
    @(negedge clk);
    while (busy !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  // Pop one job's tiles and check row-major order
  task automatic check_tiles(input job_cfg_t j);
    int        mt;
    int        nt;
    int        r;
    int        c;
    tile_cmd_t got;
    tile_cmd_t exp;
    mt = tiles_for(int'(j.m), int'(TILE_ROWS));
    nt = tiles_for(int'(j.n), int'(TILE_COLS));
    compare_count("tile command count", tile_q.size(), mt * nt);
    for (r = 0; r < mt; r++) begin
      for (c = 0; c < nt; c++) begin
        got = tile_q.pop_front();
        exp.valid = 1'b1;
        exp.row = TILE_W'(r);
        exp.col = TILE_W'(c);
        exp.last = (r == mt - 1) && (c == nt - 1);
        compare_tile(got, exp);
      end
    end
  endtask

  task automatic run_job(input job_cfg_t j);
    clear_monitor();
    start_job(j);
    wait_evt(1);
    check_tiles(j);
    // Quiet period after the event
    repeat (5) @(posedge clk);
    compare_count("evt_o pulses", evt_cnt, 1);
    compare_count("tile commands after evt_o", tile_q.size(), 0);
    @(negedge clk);
    compare_busy(busy, 1'b0);
  endtask

  task automatic readback_regs();
    reg_read(ADDR_STATUS, 32'd0);
    reg_write(ADDR_M, 32'h0000_00ab);
    reg_write(ADDR_N, 32'h0000_1234);
    reg_write(ADDR_K, 32'h0000_beef);
    reg_read(ADDR_M, 32'h0000_00ab);
    reg_read(ADDR_N, 32'h0000_1234);
    reg_read(ADDR_K, 32'h0000_beef);
    reg_read(ADDR_STATUS, 32'd0);
  endtask

  task automatic busy_during_job();
    clear_monitor();
    start_job(jobs[5]);
    wait_busy();
    reg_read(ADDR_STATUS, 32'd1);
    wait_evt(1);
    check_tiles(jobs[5]);
    reg_read(ADDR_STATUS, 32'd0);
  endtask

  // Second trigger lands while the first job is still busy
  task automatic queued_trigger();
    clear_monitor();
    start_job(jobs[6]);
    wait_busy();
    reg_write(ADDR_M, REG_W'(jobs[7].m));
    reg_write(ADDR_N, REG_W'(jobs[7].n));
    reg_write(ADDR_K, REG_W'(jobs[7].k));
    // Counts relatch on trigger so the trigger waits for the last tile of job 6
    @(negedge clk);
    while (!(tile.valid && tile.last)) begin
      @(negedge clk);
    end
    reg_write(ADDR_TRIGGER, '0);
    wait_evt(1);
    check_tiles(jobs[6]);
    wait_evt(2);
    check_tiles(jobs[7]);
    repeat (5) @(posedge clk);
    compare_count("evt_o pulses", evt_cnt, 2);
    compare_count("tile commands after evt_o", tile_q.size(), 0);
  endtask

  task automatic reset_during_job();
    clear_monitor();
    start_job(jobs[8]);
    @(negedge clk);
    while (tile.valid !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    compare_busy(busy, 1'b0);
    compare_flag("evt_o", evt, 1'b0);
    compare_tile(tile, '0);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    run_job(jobs[9]);
  endtask

  initial begin
    int total;
    rst_n = 1'b0;
    req = '0;
    total = 0;
    void'($urandom(SEED));
    jobs[0] = make_job(1 + $urandom % 64, 1 + $urandom % 40, $urandom % 20);
    // Exact multiples, single element and zero clamp
    jobs[1] = make_job(32, 16, 3);
    jobs[2] = make_job(1, 1, 1);
    jobs[3] = make_job(0, 0, 0);
    jobs[4] = make_job(48, 0, 5);
    jobs[5] = make_job(20, 12, 12);
    jobs[6] = make_job(40, 20, 24);
    // K matches job 6 since its write lands during that job's weight load
    jobs[7] = make_job(1 + $urandom % 64, 1 + $urandom % 40, 24);
    jobs[8] = make_job(64, 64, 10);
    jobs[9] = make_job(17, 9, 2);
    for (int i = 0; i < NUM_JOBS; i++) begin
      total += job_budget(jobs[i]);
    end
    cycle_limit = 2 * total;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    readback_regs();
    run_job(jobs[0]);
    for (int i = 1; i <= 4; i++) begin
      run_job(jobs[i]);
    end
    busy_during_job();
    queued_trigger();
    reset_during_job();
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
